// ==== hdl/ext_defs.svh ====
// External device cluster constants
// Bus widths, memory geometry, latencies and the register address map
`ifndef EXT_DEFS_SVH
`define EXT_DEFS_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 32

// Slow memory geometry and grant latency
`define MEM_WORDS 128
`define MEM_GNT_DELAY 3

// Register windows of 0x100 bytes
`define DMA_BASE 12'h000
`define CNT_BASE 12'h100

// Host plus the two DMA masters
`define N_OBI_MASTERS 3

`endif

// ==== hdl/obi_pkg.sv ====
// OBI memory bus types
// Shared by the host port, the DMA masters, the arbiter and the slow memory
`default_nettype none

`include "ext_defs.svh"

package obi_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`DATA_W/8-1:0] be_t;

endpackage

`default_nettype wire

// ==== hdl/reg_pkg.sv ====
// Register bus types
// Address and data of the peripheral bus and the decoded peripheral index
`default_nettype none

`include "ext_defs.svh"

package reg_pkg;

  typedef logic [11:0] reg_addr_t;
  typedef logic [`DATA_W-1:0] reg_data_t;

  // Peripheral selected by the register decoder
  typedef enum logic {
    PERIPH_DMA = 1'b0,
    PERIPH_CNT = 1'b1
  } periph_idx_e;

endpackage

`default_nettype wire

// ==== hdl/reg_demux.sv ====
// Register bus demultiplexer
// Decodes the address window and routes each access to the DMA or the counter
`timescale 1ns/100ps
`default_nettype none

`include "ext_defs.svh"

module reg_demux (
  input  logic               reg_valid_i,
  input  logic               reg_write_i,
  input  reg_pkg::reg_addr_t reg_addr_i,
  input  reg_pkg::reg_data_t reg_wdata_i,
  output logic               reg_ready_o,
  output reg_pkg::reg_data_t reg_rdata_o,
  output logic               reg_error_o,
  output logic               periph_write_o,
  output reg_pkg::reg_addr_t periph_addr_o,
  output reg_pkg::reg_data_t periph_wdata_o,
  output logic               dma_valid_o,
  input  logic               dma_ready_i,
  input  reg_pkg::reg_data_t dma_rdata_i,
  output logic               cnt_valid_o,
  input  logic               cnt_ready_i,
  input  reg_pkg::reg_data_t cnt_rdata_i
);

  localparam logic [3:0] DmaPage = 4'(`DMA_BASE >> 8);
  localparam logic [3:0] CntPage = 4'(`CNT_BASE >> 8);

  reg_pkg::periph_idx_e idx;
  logic                 hit;

  always_comb begin
    hit = 1'b1;
    idx = reg_pkg::PERIPH_DMA;
    case (reg_addr_i[11:8])
      DmaPage: idx = reg_pkg::PERIPH_DMA;
      CntPage: idx = reg_pkg::PERIPH_CNT;
      default: hit = 1'b0;
    endcase
  end

  assign periph_write_o = reg_write_i;
  assign periph_addr_o  = reg_addr_i;
  assign periph_wdata_o = reg_wdata_i;

  assign dma_valid_o = reg_valid_i & hit & (idx == reg_pkg::PERIPH_DMA);
  assign cnt_valid_o = reg_valid_i & hit & (idx == reg_pkg::PERIPH_CNT);

  // Misses are answered here with an error and zero data
  always_comb begin
    if (!hit) begin
      reg_ready_o = reg_valid_i;
      reg_rdata_o = '0;
    end else if (idx == reg_pkg::PERIPH_CNT) begin
      reg_ready_o = cnt_ready_i;
      reg_rdata_o = cnt_rdata_i;
    end else begin
      reg_ready_o = dma_ready_i;
      reg_rdata_o = dma_rdata_i;
    end
  end

  assign reg_error_o = reg_valid_i & ~hit;

endmodule

`default_nettype wire

// ==== hdl/obi_arbiter.sv ====
// Round-robin OBI arbiter
// Shares one slave among several masters and locks the route from grant to rvalid
`timescale 1ns/100ps
`default_nettype none

module obi_arbiter #(
  parameter int NumMasters = 2
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic           [NumMasters-1:0] m_req_i,
  input  logic           [NumMasters-1:0] m_we_i,
  input  obi_pkg::be_t   [NumMasters-1:0] m_be_i,
  input  obi_pkg::addr_t [NumMasters-1:0] m_addr_i,
  input  obi_pkg::data_t [NumMasters-1:0] m_wdata_i,
  output logic           [NumMasters-1:0] m_gnt_o,
  output logic           [NumMasters-1:0] m_rvalid_o,
  output obi_pkg::data_t [NumMasters-1:0] m_rdata_o,
  output logic                             s_req_o,
  output logic                             s_we_o,
  output obi_pkg::be_t                     s_be_o,
  output obi_pkg::addr_t                   s_addr_o,
  output obi_pkg::data_t                   s_wdata_o,
  input  logic                             s_gnt_i,
  input  logic                             s_rvalid_i,
  input  obi_pkg::data_t                   s_rdata_i
);

  localparam int IdxW = (NumMasters > 1) ? $clog2(NumMasters) : 1;

  logic [IdxW-1:0] rr_ptr_q;
  logic [IdxW-1:0] owner_q;
  logic [IdxW-1:0] pick;
  logic [IdxW-1:0] route;
  logic            locked_q;
  logic            any_req;

  // Search downwards so the master closest to the pointer wins
  always_comb begin
    int unsigned cand;
    pick    = rr_ptr_q;
    any_req = 1'b0;
    for (int i = NumMasters - 1; i >= 0; i--) begin
      cand = int'(rr_ptr_q) + i;
      if (cand >= NumMasters) begin
        cand = cand - NumMasters;
      end
      if (m_req_i[cand]) begin
        pick    = IdxW'(cand);
        any_req = 1'b1;
      end
    end
  end

  assign route     = locked_q ? owner_q : pick;
  assign s_req_o   = any_req & ~locked_q;
  assign s_we_o    = m_we_i[route];
  assign s_be_o    = m_be_i[route];
  assign s_addr_o  = m_addr_i[route];
  assign s_wdata_o = m_wdata_i[route];
  assign m_rdata_o = {NumMasters{s_rdata_i}};

  always_comb begin
    m_gnt_o           = '0;
    m_rvalid_o        = '0;
    m_gnt_o[pick]     = s_gnt_i & ~locked_q;
    m_rvalid_o[owner_q] = s_rvalid_i & locked_q;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q <= '0;
      owner_q  <= '0;
      locked_q <= 1'b0;
    end else if (s_req_o && s_gnt_i) begin
      locked_q <= 1'b1;
      owner_q  <= pick;
      rr_ptr_q <= (pick == IdxW'(NumMasters - 1)) ? '0 : pick + 1'b1;
    end else if (locked_q && s_rvalid_i) begin
      locked_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/slow_memory.sv ====
// Slow single-port word memory
// Grants a held request after a fixed wait, rvalid follows the grant by one cycle
`timescale 1ns/100ps
`default_nettype none

`include "ext_defs.svh"

module slow_memory (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  obi_pkg::be_t                  be_i,
  input  logic [$clog2(`MEM_WORDS)-1:0] addr_i,
  input  obi_pkg::data_t                wdata_i,
  output logic                          gnt_o,
  output logic                          rvalid_o,
  output obi_pkg::data_t                rdata_o
);

  localparam int CntW = $clog2(`MEM_GNT_DELAY + 1);
  localparam int NumBytes = $bits(obi_pkg::be_t);

  obi_pkg::data_t mem_q [`MEM_WORDS];
  obi_pkg::data_t rdata_q;
  logic [CntW-1:0] wait_q;
  logic            rvalid_q;

  assign gnt_o    = req_i & (wait_q == CntW'(`MEM_GNT_DELAY));
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // Wait counter restarts after every grant or dropped request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
      if (!req_i || gnt_o) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        for (int b = 0; b < NumBytes; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dma_memcopy.sv ====
// Memcopy DMA
// Copies SIZE words from SRC to DST over separate OBI read and write masters
// and flags completion in STATUS and on the interrupt line
`timescale 1ns/100ps
`default_nettype none

module dma_memcopy (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               reg_valid_i,
  input  logic               reg_write_i,
  input  reg_pkg::reg_addr_t reg_addr_i,
  input  reg_pkg::reg_data_t reg_wdata_i,
  output logic               reg_ready_o,
  output reg_pkg::reg_data_t reg_rdata_o,
  output logic               rd_req_o,
  output obi_pkg::addr_t     rd_addr_o,
  input  logic               rd_gnt_i,
  input  logic               rd_rvalid_i,
  input  obi_pkg::data_t     rd_rdata_i,
  output logic               wr_req_o,
  output obi_pkg::addr_t     wr_addr_o,
  output obi_pkg::data_t     wr_wdata_o,
  input  logic               wr_gnt_i,
  input  logic               wr_rvalid_i,
  output logic               intr_o
);

  typedef enum logic [2:0] {IDLE, RD_REQ, RD_WAIT, WR_REQ, WR_WAIT} state_e;

  localparam logic [7:0] OffSrc    = 8'h00;
  localparam logic [7:0] OffDst    = 8'h04;
  localparam logic [7:0] OffSize   = 8'h08;
  localparam logic [7:0] OffStatus = 8'h0C;
  localparam logic [7:0] OffIe     = 8'h10;

  state_e             state_q;
  obi_pkg::addr_t     src_q;
  obi_pkg::addr_t     dst_q;
  obi_pkg::addr_t     rd_addr_q;
  obi_pkg::addr_t     wr_addr_q;
  obi_pkg::data_t     buf_q;
  reg_pkg::reg_data_t size_q;
  reg_pkg::reg_data_t left_q;
  logic               ie_q;
  logic               done_q;
  logic               intr_q;
  logic [7:0]         offset;
  logic               reg_wr;
  logic               start;

  assign offset      = reg_addr_i[7:0];
  assign reg_wr      = reg_valid_i & reg_write_i;
  assign reg_ready_o = reg_valid_i;

  // A SIZE write only starts a copy from idle
  assign start = reg_wr & (offset == OffSize) & (state_q == IDLE) & (reg_wdata_i != '0);

  always_comb begin
    case (offset)
      OffSrc:    reg_rdata_o = src_q;
      OffDst:    reg_rdata_o = dst_q;
      OffSize:   reg_rdata_o = size_q;
      OffStatus: reg_rdata_o = reg_pkg::reg_data_t'(done_q);
      OffIe:     reg_rdata_o = reg_pkg::reg_data_t'(ie_q);
      default:   reg_rdata_o = '0;
    endcase
  end

  assign rd_req_o   = (state_q == RD_REQ);
  assign rd_addr_o  = rd_addr_q;
  assign wr_req_o   = (state_q == WR_REQ);
  assign wr_addr_o  = wr_addr_q;
  assign wr_wdata_o = buf_q;
  assign intr_o     = intr_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      src_q   <= '0;
      dst_q   <= '0;
      size_q  <= '0;
      ie_q    <= 1'b0;
      done_q  <= 1'b0;
      intr_q  <= 1'b0;
    end else begin
      if (reg_wr) begin
        case (offset)
          OffSrc:  src_q <= reg_wdata_i;
          OffDst:  dst_q <= reg_wdata_i;
          OffSize: begin
            if (state_q == IDLE) begin
              size_q <= reg_wdata_i;
            end
          end
          OffIe:   ie_q <= reg_wdata_i[0];
          default: ;
        endcase
      end
      // Reading STATUS acknowledges the interrupt
      if (reg_valid_i && !reg_write_i && offset == OffStatus) begin
        intr_q <= 1'b0;
      end
      if (start) begin
        done_q <= 1'b0;
      end
      case (state_q)
        IDLE:    if (start) state_q <= RD_REQ;
        RD_REQ:  if (rd_gnt_i) state_q <= RD_WAIT;
        RD_WAIT: if (rd_rvalid_i) state_q <= WR_REQ;
        WR_REQ:  if (wr_gnt_i) state_q <= WR_WAIT;
        WR_WAIT: begin
          if (wr_rvalid_i) begin
            if (left_q == reg_pkg::reg_data_t'(1)) begin
              state_q <= IDLE;
              done_q  <= 1'b1;
              if (ie_q) begin
                intr_q <= 1'b1;
              end
            end else begin
              state_q <= RD_REQ;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      rd_addr_q <= src_q;
      wr_addr_q <= dst_q;
      left_q    <= reg_wdata_i;
    end
    if (state_q == RD_WAIT && rd_rvalid_i) begin
      buf_q <= rd_rdata_i;
    end
    if (state_q == WR_WAIT && wr_rvalid_i) begin
      rd_addr_q <= rd_addr_q + 32'd4;
      wr_addr_q <= wr_addr_q + 32'd4;
      left_q    <= left_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/gpio_cnt.sv ====
// GPIO edge counter
// Counts rising input edges and toggles the output every LIMIT edges
`timescale 1ns/100ps
`default_nettype none

module gpio_cnt (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               reg_valid_i,
  input  logic               reg_write_i,
  input  reg_pkg::reg_addr_t reg_addr_i,
  input  reg_pkg::reg_data_t reg_wdata_i,
  output logic               reg_ready_o,
  output reg_pkg::reg_data_t reg_rdata_o,
  input  logic               gpio_i,
  output logic               gpio_o
);

  localparam logic [7:0] OffLimit = 8'h00;
  localparam logic [7:0] OffCount = 8'h04;

  reg_pkg::reg_data_t limit_q;
  reg_pkg::reg_data_t count_q;
  reg_pkg::reg_data_t count_inc;
  logic               sync_q;
  logic               prev_q;
  logic               gpio_q;
  logic               rise;
  logic               limit_wr;

  assign rise      = sync_q & ~prev_q;
  assign count_inc = count_q + 1'b1;
  assign limit_wr  = reg_valid_i & reg_write_i & (reg_addr_i[7:0] == OffLimit);

  assign reg_ready_o = reg_valid_i;
  assign reg_rdata_o = (reg_addr_i[7:0] == OffLimit) ? limit_q :
                       (reg_addr_i[7:0] == OffCount) ? count_q : '0;
  assign gpio_o      = gpio_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q  <= 1'b0;
      prev_q  <= 1'b0;
      gpio_q  <= 1'b0;
      limit_q <= '0;
      count_q <= '0;
    end else begin
      sync_q <= gpio_i;
      prev_q <= sync_q;
      // New limit restarts the count, zero disables counting
      if (limit_wr) begin
        limit_q <= reg_wdata_i;
        count_q <= '0;
      end else if (rise && limit_q != '0) begin
        if (count_inc == limit_q) begin
          count_q <= '0;
          gpio_q  <= ~gpio_q;
        end else begin
          count_q <= count_inc;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ext_device_cluster.sv ====
// External device cluster top
// Register demux with DMA and GPIO counter, plus the arbitrated slow memory
`timescale 1ns/100ps
`default_nettype none

`include "ext_defs.svh"

module ext_device_cluster (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               reg_valid_i,
  input  logic               reg_write_i,
  input  reg_pkg::reg_addr_t reg_addr_i,
  input  reg_pkg::reg_data_t reg_wdata_i,
  output logic               reg_ready_o,
  output reg_pkg::reg_data_t reg_rdata_o,
  output logic               reg_error_o,
  input  logic               host_req_i,
  input  logic               host_we_i,
  input  obi_pkg::be_t       host_be_i,
  input  obi_pkg::addr_t     host_addr_i,
  input  obi_pkg::data_t     host_wdata_i,
  output logic               host_gnt_o,
  output logic               host_rvalid_o,
  output obi_pkg::data_t     host_rdata_o,
  input  logic               gpio_i,
  output logic               gpio_o,
  output logic               intr_o
);

  // Register side
  logic               periph_write;
  reg_pkg::reg_addr_t periph_addr;
  reg_pkg::reg_data_t periph_wdata;
  logic               dma_valid;
  logic               dma_ready;
  reg_pkg::reg_data_t dma_rdata;
  logic               cnt_valid;
  logic               cnt_ready;
  reg_pkg::reg_data_t cnt_rdata;

  // Memory side, master 0 host, 1 DMA read, 2 DMA write
  logic           [`N_OBI_MASTERS-1:0] m_req;
  logic           [`N_OBI_MASTERS-1:0] m_we;
  logic           [`N_OBI_MASTERS-1:0] m_gnt;
  logic           [`N_OBI_MASTERS-1:0] m_rvalid;
  obi_pkg::be_t   [`N_OBI_MASTERS-1:0] m_be;
  obi_pkg::addr_t [`N_OBI_MASTERS-1:0] m_addr;
  obi_pkg::data_t [`N_OBI_MASTERS-1:0] m_wdata;
  obi_pkg::data_t [`N_OBI_MASTERS-1:0] m_rdata;
  logic           dma_rd_req;
  logic           dma_wr_req;
  obi_pkg::addr_t dma_rd_addr;
  obi_pkg::addr_t dma_wr_addr;
  obi_pkg::data_t dma_wr_wdata;
  logic           s_req;
  logic           s_we;
  logic           s_gnt;
  logic           s_rvalid;
  obi_pkg::be_t   s_be;
  obi_pkg::addr_t s_addr;
  obi_pkg::data_t s_wdata;
  obi_pkg::data_t s_rdata;

  // DMA masters always move whole words, the read master never writes
  assign m_req   = {dma_wr_req, dma_rd_req, host_req_i};
  assign m_we    = {1'b1, 1'b0, host_we_i};
  assign m_be    = {4'hF, 4'hF, host_be_i};
  assign m_addr  = {dma_wr_addr, dma_rd_addr, host_addr_i};
  assign m_wdata = {dma_wr_wdata, obi_pkg::data_t'(0), host_wdata_i};

  assign host_gnt_o    = m_gnt[0];
  assign host_rvalid_o = m_rvalid[0];
  assign host_rdata_o  = m_rdata[0];

  reg_demux u_reg_demux (
    .reg_valid_i    (reg_valid_i),
    .reg_write_i    (reg_write_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_ready_o    (reg_ready_o),
    .reg_rdata_o    (reg_rdata_o),
    .reg_error_o    (reg_error_o),
    .periph_write_o (periph_write),
    .periph_addr_o  (periph_addr),
    .periph_wdata_o (periph_wdata),
    .dma_valid_o    (dma_valid),
    .dma_ready_i    (dma_ready),
    .dma_rdata_i    (dma_rdata),
    .cnt_valid_o    (cnt_valid),
    .cnt_ready_i    (cnt_ready),
    .cnt_rdata_i    (cnt_rdata)
  );

  dma_memcopy u_dma_memcopy (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .reg_valid_i (dma_valid),
    .reg_write_i (periph_write),
    .reg_addr_i  (periph_addr),
    .reg_wdata_i (periph_wdata),
    .reg_ready_o (dma_ready),
    .reg_rdata_o (dma_rdata),
    .rd_req_o    (dma_rd_req),
    .rd_addr_o   (dma_rd_addr),
    .rd_gnt_i    (m_gnt[1]),
    .rd_rvalid_i (m_rvalid[1]),
    .rd_rdata_i  (m_rdata[1]),
    .wr_req_o    (dma_wr_req),
    .wr_addr_o   (dma_wr_addr),
    .wr_wdata_o  (dma_wr_wdata),
    .wr_gnt_i    (m_gnt[2]),
    .wr_rvalid_i (m_rvalid[2]),
    .intr_o      (intr_o)
  );

  gpio_cnt u_gpio_cnt (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .reg_valid_i (cnt_valid),
    .reg_write_i (periph_write),
    .reg_addr_i  (periph_addr),
    .reg_wdata_i (periph_wdata),
    .reg_ready_o (cnt_ready),
    .reg_rdata_o (cnt_rdata),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o)
  );

  obi_arbiter #(
    .NumMasters (`N_OBI_MASTERS)
  ) u_obi_arbiter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .m_req_i    (m_req),
    .m_we_i     (m_we),
    .m_be_i     (m_be),
    .m_addr_i   (m_addr),
    .m_wdata_i  (m_wdata),
    .m_gnt_o    (m_gnt),
    .m_rvalid_o (m_rvalid),
    .m_rdata_o  (m_rdata),
    .s_req_o    (s_req),
    .s_we_o     (s_we),
    .s_be_o     (s_be),
    .s_addr_o   (s_addr),
    .s_wdata_o  (s_wdata),
    .s_gnt_i    (s_gnt),
    .s_rvalid_i (s_rvalid),
    .s_rdata_i  (s_rdata)
  );

  slow_memory u_slow_memory (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (s_req),
    .we_i     (s_we),
    .be_i     (s_be),
    .addr_i   (s_addr[8:2]),
    .wdata_i  (s_wdata),
    .gnt_o    (s_gnt),
    .rvalid_o (s_rvalid),
    .rdata_o  (s_rdata)
  );

endmodule

`default_nettype wire

// ==== tests/tb_tasks.svh ====
// Host bus drivers, checks and directed tests
// Included inside the testbench top module
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_eq(input string label, input logic [31:0] exp,
                          input logic [31:0] act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %s: %s expected 0x%08h actual 0x%08h",
                          test_name, label, exp, act));
    end
  endtask

  // Ready is sampled away from the clock edge
  task automatic reg_access(input logic wr, input reg_pkg::reg_addr_t addr,
                            input reg_pkg::reg_data_t wdata,
                            output reg_pkg::reg_data_t rdata, output logic err);
    int n;
    @(negedge clk);
    reg_valid = 1'b1;
    reg_we    = wr;
    reg_addr  = addr;
    reg_wdata = wdata;
    n = 0;
    #1;
    while (reg_ready !== 1'b1) begin
      if (n == TimeoutCycles) begin
        fail_stop($sformatf("Register access to 0x%03h never got ready", addr));
      end
      @(negedge clk);
      #1;
      n++;
    end
    // Ready comes in the same cycle as valid
    check_eq($sformatf("cycles to ready at 0x%03h", addr), 0, n);
    rdata = reg_rdata;
    err   = reg_error;
    @(posedge clk);
    @(negedge clk);
    reg_valid = 1'b0;
    reg_we    = 1'b0;
  endtask

  task automatic reg_write(input reg_pkg::reg_addr_t addr, input reg_pkg::reg_data_t data);
    reg_pkg::reg_data_t rd;
    logic err;
    reg_access(1'b1, addr, data, rd, err);
    check_eq($sformatf("error on write to 0x%03h", addr), 0, err);
  endtask

  task automatic reg_read(input reg_pkg::reg_addr_t addr, output reg_pkg::reg_data_t data);
    logic err;
    reg_access(1'b0, addr, '0, data, err);
    check_eq($sformatf("error on read of 0x%03h", addr), 0, err);
  endtask

  // Host OBI access holds until gnt and then collects rvalid
  task automatic mem_access(input logic we, input obi_pkg::be_t be, input int word,
                            input obi_pkg::data_t wdata, output obi_pkg::data_t rdata);
    int n;
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = we;
    host_be    = be;
    host_addr  = obi_pkg::addr_t'(word * 4);
    host_wdata = wdata;
    n = 0;
    #1;
    while (host_gnt !== 1'b1) begin
      if (n == TimeoutCycles) begin
        fail_stop($sformatf("Host access to word %0d was never granted", word));
      end
      @(negedge clk);
      #1;
      n++;
    end
    @(posedge clk);
    @(negedge clk);
    host_req = 1'b0;
    n = 0;
    #1;
    while (host_rvalid !== 1'b1) begin
      if (n == TimeoutCycles) begin
        fail_stop($sformatf("Host access to word %0d got no rvalid", word));
      end
      @(negedge clk);
      #1;
      n++;
    end
    // rvalid follows the grant by exactly one cycle
    check_eq($sformatf("cycles from gnt to rvalid for word %0d", word), 0, n);
    rdata = host_rdata;
  endtask

  task automatic mem_write(input int word, input obi_pkg::be_t be, input obi_pkg::data_t data);
    obi_pkg::data_t rd;
    mem_access(1'b1, be, word, data, rd);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        exp_mem[word][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic mem_read(input int word, output obi_pkg::data_t data);
    mem_access(1'b0, 4'h0, word, '0, data);
  endtask

  task automatic mem_fill(input int first, input int count);
    for (int w = first; w < first + count; w++) begin
      mem_write(w, 4'hF, $urandom());
    end
  endtask

  task automatic mem_expect(input int first, input int count);
    obi_pkg::data_t d;
    for (int w = first; w < first + count; w++) begin
      mem_read(w, d);
      check_eq($sformatf("memory word %0d", w), exp_mem[w], d);
    end
  endtask

  task automatic start_copy(input int src, input int dst, input int count, input logic ie);
    reg_write(`DMA_BASE + 12'h000, src * 4);
    reg_write(`DMA_BASE + 12'h004, dst * 4);
    reg_write(`DMA_BASE + 12'h010, ie);
    reg_write(`DMA_BASE + 12'h008, count);
  endtask

  // Destination takes the source words and the guard words around it stay
  task automatic copy_expect(input int src, input int dst, input int count);
    for (int i = 0; i < count; i++) begin
      exp_mem[dst + i] = exp_mem[src + i];
    end
    mem_expect(dst - 1, count + 2);
  endtask

  task automatic wait_intr();
    int n;
    n = 0;
    while (intr !== 1'b1) begin
      if (n == TimeoutCycles) begin
        fail_stop("DMA interrupt never arrived");
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic test_mem_round_trip();
    test_name = "mem_round_trip";
    mem_fill(0, 16);
    mem_expect(0, 16);
    mem_write(3, 4'b0101, $urandom());
    mem_write(9, 4'b1000, $urandom());
    mem_write(12, 4'b0010, $urandom());
    mem_expect(0, 16);
  endtask

  task automatic test_reg_decode();
    reg_pkg::reg_data_t v;
    reg_pkg::reg_data_t rd;
    logic err;
    test_name = "reg_decode";
    v = $urandom();
    reg_write(`DMA_BASE + 12'h000, v);
    reg_read(`DMA_BASE + 12'h000, rd);
    check_eq("DMA SRC", v, rd);
    v = $urandom();
    reg_write(`DMA_BASE + 12'h004, v);
    reg_read(`DMA_BASE + 12'h004, rd);
    check_eq("DMA DST", v, rd);
    reg_write(`DMA_BASE + 12'h010, 1);
    reg_read(`DMA_BASE + 12'h010, rd);
    check_eq("DMA IE", 1, rd);
    v = $urandom();
    reg_write(`CNT_BASE + 12'h000, v);
    reg_read(`CNT_BASE + 12'h000, rd);
    check_eq("counter LIMIT", v, rd);
    // COUNT ignores writes
    reg_write(`CNT_BASE + 12'h004, 32'h5);
    reg_read(`CNT_BASE + 12'h004, rd);
    check_eq("counter COUNT", 0, rd);
    reg_write(`CNT_BASE + 12'h000, 0);
    reg_access(1'b0, 12'h200, '0, rd, err);
    check_eq("error on read outside windows", 1, err);
    check_eq("rdata on read outside windows", 0, rd);
    reg_access(1'b1, 12'hF04, $urandom(), rd, err);
    check_eq("error on write outside windows", 1, err);
    check_eq("rdata on write outside windows", 0, rd);
  endtask

  task automatic test_memcopy();
    reg_pkg::reg_data_t rd;
    test_name = "memcopy";
    mem_fill(32, 8);
    mem_fill(63, 1);
    mem_fill(72, 1);
    start_copy(32, 64, 8, 1'b1);
    wait_intr();
    copy_expect(32, 64, 8);
    check_eq("intr before STATUS read", 1, intr);
    reg_read(`DMA_BASE + 12'h008, rd);
    check_eq("DMA SIZE", 8, rd);
    reg_read(`DMA_BASE + 12'h00C, rd);
    check_eq("DMA STATUS", 1, rd);
    check_eq("intr after STATUS read", 0, intr);
  endtask

  task automatic test_copy_no_irq();
    reg_pkg::reg_data_t rd;
    int n;
    test_name = "copy_no_irq";
    mem_fill(40, 4);
    mem_fill(79, 1);
    mem_fill(84, 1);
    start_copy(40, 80, 4, 1'b0);
    n  = 0;
    rd = '0;
    while (rd[0] !== 1'b1) begin
      if (n == TimeoutCycles) begin
        fail_stop("Copy with interrupt disabled never finished");
      end
      reg_read(`DMA_BASE + 12'h00C, rd);
      check_eq("intr while IE is zero", 0, intr);
      n++;
    end
    copy_expect(40, 80, 4);
    check_eq("intr after copy", 0, intr);
  endtask

  // Host reads compete with the running copy
  task automatic test_arbitration();
    reg_pkg::reg_data_t rd;
    test_name = "arbitration";
    mem_fill(32, 8);
    mem_fill(95, 1);
    mem_fill(104, 1);
    start_copy(32, 96, 8, 1'b1);
    mem_expect(0, 16);
    wait_intr();
    copy_expect(32, 96, 8);
    reg_read(`DMA_BASE + 12'h00C, rd);
    check_eq("DMA STATUS", 1, rd);
    check_eq("intr after STATUS read", 0, intr);
  endtask

  task automatic test_gpio_counter();
    reg_pkg::reg_data_t rd;
    int   limit;
    int   toggles;
    logic last;
    test_name = "gpio_counter";
    limit = 2 + ($urandom() % 4);
    reg_write(`CNT_BASE + 12'h000, limit);
    toggles = 0;
    last    = gpio_out;
    for (int e = 1; e <= 3 * limit; e++) begin
      // Three cycles high and three low with the output sampled every cycle
      for (int c = 0; c < 6; c++) begin
        @(negedge clk);
        gpio_in = (c < 3);
        if (gpio_out !== last) begin
          toggles++;
          last = gpio_out;
        end
      end
      check_eq($sformatf("toggles after edge %0d", e), e / limit, toggles);
    end
    check_eq("total toggles", 3, toggles);
    reg_read(`CNT_BASE + 12'h004, rd);
    check_eq("counter COUNT", 0, rd);
    reg_write(`CNT_BASE + 12'h000, 0);
  endtask

`endif

// ==== tests/tb_ext_device_cluster.sv ====
// Testbench for the external device cluster
// Plays the host on the register bus and on the OBI memory port
`timescale 1ns/100ps
`default_nettype none

`include "ext_defs.svh"

module tb_ext_device_cluster;

  localparam int TimeoutCycles = 2000;

  logic               clk;
  logic               arst_n;
  logic               reg_valid;
  logic               reg_we;
  reg_pkg::reg_addr_t reg_addr;
  reg_pkg::reg_data_t reg_wdata;
  logic               reg_ready;
  reg_pkg::reg_data_t reg_rdata;
  logic               reg_error;
  logic               host_req;
  logic               host_we;
  obi_pkg::be_t       host_be;
  obi_pkg::addr_t     host_addr;
  obi_pkg::data_t     host_wdata;
  logic               host_gnt;
  logic               host_rvalid;
  obi_pkg::data_t     host_rdata;
  logic               gpio_in;
  logic               gpio_out;
  logic               intr;

  // Host view of the memory contents
  obi_pkg::data_t exp_mem [`MEM_WORDS];
  string          test_name;

  ext_device_cluster u_ext_device_cluster (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .reg_valid_i   (reg_valid),
    .reg_write_i   (reg_we),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_ready_o   (reg_ready),
    .reg_rdata_o   (reg_rdata),
    .reg_error_o   (reg_error),
    .host_req_i    (host_req),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .intr_o        (intr)
  );

  `include "tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  initial begin
    void'($urandom(32'hd8b7cc91));
    test_name  = "reset";
    arst_n     = 1'b0;
    reg_valid  = 1'b0;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_be    = '0;
    host_addr  = '0;
    host_wdata = '0;
    gpio_in    = 1'b0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_eq("gnt rvalid intr gpio after reset", 0, {host_gnt, host_rvalid, intr, gpio_out});

    test_mem_round_trip();
    test_reg_decode();
    test_memcopy();
    test_copy_no_irq();
    test_arbitration();
    test_gpio_counter();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
+incdir+tests
hdl/obi_pkg.sv
hdl/reg_pkg.sv
hdl/reg_demux.sv
hdl/obi_arbiter.sv
hdl/slow_memory.sv
hdl/dma_memcopy.sv
hdl/gpio_cnt.sv
hdl/ext_device_cluster.sv
tests/tb_ext_device_cluster.sv

// ==== Makefile ====
# Verilator build of the external device cluster testbench
# The run target fails when the simulation stops on $fatal

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	  -f verilog.f --top-module tb_ext_device_cluster -Mdir obj_dir

run: compile
	./obj_dir/Vtb_ext_device_cluster

clean:
	rm -rf obj_dir
